// ==== Makefile ====
# Verilator build and run of the Sv39 MMU testbench

SIM := obj_dir/Vtb_mmu

# rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard source/*.sv) tests/tb_mmu.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu -f src.f --Mdir obj_dir -o Vtb_mmu

# pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== source/mmu_pkg.sv ====
/*
 * Sv39 MMU shared definitions: address widths, PTE and TLB entry layouts,
 * fault codes, PMP configuration and walker states
 */
package mmu_pkg;

  // address widths
  localparam int VLEN = 39;
  localparam int PLEN = 56;
  localparam int PPNW = 44;
  // three 9-bit vpn fields
  localparam int VPNW = 27;

  // pte permission and status flags, low byte of a pte
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  typedef struct packed {
    logic [9:0]      reserved;
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    pte_flags_t      flags;
  } pte_t;

  // LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
  typedef enum logic [1:0] {LVL1, LVL2, LVL3} level_e;

  typedef struct packed {
    logic [VPNW-1:0] vpn;
    logic [PPNW-1:0] ppn;
    level_e          level;
    pte_flags_t      flags;
  } tlb_entry_t;

  typedef enum logic [1:0] {FAULT_NONE, FAULT_PAGE, FAULT_ACCESS} fault_e;

  typedef enum logic [1:0] {PMP_OFF, PMP_TOR, PMP_NAPOT} pmp_mode_e;

  typedef struct packed {
    pmp_mode_e mode;
    logic      r;
  } pmp_cfg_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, WB_READ, PTE_CHECK, RESPOND, DRAIN} ptw_state_e;

endpackage

// ==== source/mmu_top.sv ====
/*
 * Sv39 MMU top level: instruction and data TLBs with a shared walker
 */
`timescale 1ns/100ps

module mmu_top #(
  parameter int TLB_ENTRIES = 4,
  parameter int PMP_ENTRIES = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       enable_translation_i,
  input  logic                                       mxr_i,
  input  logic [mmu_pkg::PPNW-1:0]                   satp_ppn_i,
  input  mmu_pkg::pmp_cfg_t [PMP_ENTRIES-1:0]        pmp_cfg_i,
  input  logic [PMP_ENTRIES-1:0][mmu_pkg::PLEN-3:0]  pmp_addr_i,
  // instruction fetch requester
  input  logic                                       ifetch_req_i,
  input  logic [mmu_pkg::VLEN-1:0]                   ifetch_vaddr_i,
  output logic                                       ifetch_valid_o,
  output logic [mmu_pkg::PLEN-1:0]                   ifetch_paddr_o,
  output mmu_pkg::fault_e                            ifetch_fault_o,
  // load/store requester
  input  logic                                       lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]                   lsu_vaddr_i,
  input  logic                                       lsu_is_store_i,
  output logic                                       lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]                   lsu_paddr_o,
  output mmu_pkg::fault_e                            lsu_fault_o,
  // wishbone read master
  output logic                                       wb_cyc_o,
  output logic                                       wb_stb_o,
  output logic [mmu_pkg::PLEN-1:0]                   wb_adr_o,
  input  logic [63:0]                                wb_dat_i,
  input  logic                                       wb_ack_i,
  input  logic                                       wb_err_i
);

  tlb_if itlb_bus ();
  tlb_if dtlb_bus ();

  tlb #(.TLB_ENTRIES (TLB_ENTRIES)) i_itlb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .bus     (itlb_bus)
  );

  tlb #(.TLB_ENTRIES (TLB_ENTRIES)) i_dtlb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .bus     (dtlb_bus)
  );

  ptw #(.PMP_ENTRIES (PMP_ENTRIES)) i_ptw (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .enable_translation_i (enable_translation_i),
    .mxr_i                (mxr_i),
    .satp_ppn_i           (satp_ppn_i),
    .pmp_cfg_i            (pmp_cfg_i),
    .pmp_addr_i           (pmp_addr_i),
    .ifetch_req_i         (ifetch_req_i),
    .ifetch_vaddr_i       (ifetch_vaddr_i),
    .ifetch_valid_o       (ifetch_valid_o),
    .ifetch_paddr_o       (ifetch_paddr_o),
    .ifetch_fault_o       (ifetch_fault_o),
    .lsu_req_i            (lsu_req_i),
    .lsu_vaddr_i          (lsu_vaddr_i),
    .lsu_is_store_i       (lsu_is_store_i),
    .lsu_valid_o          (lsu_valid_o),
    .lsu_paddr_o          (lsu_paddr_o),
    .lsu_fault_o          (lsu_fault_o),
    .wb_cyc_o             (wb_cyc_o),
    .wb_stb_o             (wb_stb_o),
    .wb_adr_o             (wb_adr_o),
    .wb_dat_i             (wb_dat_i),
    .wb_ack_i             (wb_ack_i),
    .wb_err_i             (wb_err_i),
    .itlb                 (itlb_bus),
    .dtlb                 (dtlb_bus)
  );

endmodule

// ==== source/pmp_check.sv ====
/*
 * PMP read check of a physical address, TOR and NAPOT, lowest entry wins
 */
`timescale 1ns/100ps

module pmp_check #(
  parameter int PMP_ENTRIES = 4
) (
  input  logic [mmu_pkg::PLEN-1:0]                   addr_i,
  input  mmu_pkg::pmp_cfg_t [PMP_ENTRIES-1:0]        cfg_i,
  input  logic [PMP_ENTRIES-1:0][mmu_pkg::PLEN-3:0]  pmpaddr_i,
  output logic                                       allow_o
);

  // pmpaddr registers hold word addresses
  logic [mmu_pkg::PLEN-3:0] word_addr;

  assign word_addr = addr_i[mmu_pkg::PLEN-1:2];

  always_comb begin
    logic                     found;
    logic                     hit;
    logic [mmu_pkg::PLEN-3:0] lower;
    logic [mmu_pkg::PLEN-3:0] care;
    allow_o = 1'b0;
    found   = 1'b0;
    // entry 0 TOR range starts at zero
    lower   = '0;
    for (int i = 0; i < PMP_ENTRIES; i++) begin
      // napot: trailing ones plus one more bit are don't-care
      care = ~(pmpaddr_i[i] ^ (pmpaddr_i[i] + 1'b1));
      case (cfg_i[i].mode)
        mmu_pkg::PMP_TOR:   hit = (word_addr >= lower) && (word_addr < pmpaddr_i[i]);
        mmu_pkg::PMP_NAPOT: hit = ((word_addr ^ pmpaddr_i[i]) & care) == '0;
        default:            hit = 1'b0;
      endcase
      if (hit && !found) begin
        allow_o = cfg_i[i].r;
        found   = 1'b1;
      end
      lower = pmpaddr_i[i];
    end
  end

endmodule

// ==== source/ptw.sv ====
/*
 * request arbiter, TLB hit permission check, Sv39 page table walker FSM
 * and read-only Wishbone classic master
 */
`timescale 1ns/100ps

module ptw #(
  parameter int PMP_ENTRIES = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       enable_translation_i,
  input  logic                                       mxr_i,
  input  logic [mmu_pkg::PPNW-1:0]                   satp_ppn_i,
  input  mmu_pkg::pmp_cfg_t [PMP_ENTRIES-1:0]        pmp_cfg_i,
  input  logic [PMP_ENTRIES-1:0][mmu_pkg::PLEN-3:0]  pmp_addr_i,
  input  logic                                       ifetch_req_i,
  input  logic [mmu_pkg::VLEN-1:0]                   ifetch_vaddr_i,
  output logic                                       ifetch_valid_o,
  output logic [mmu_pkg::PLEN-1:0]                   ifetch_paddr_o,
  output mmu_pkg::fault_e                            ifetch_fault_o,
  input  logic                                       lsu_req_i,
  input  logic [mmu_pkg::VLEN-1:0]                   lsu_vaddr_i,
  input  logic                                       lsu_is_store_i,
  output logic                                       lsu_valid_o,
  output logic [mmu_pkg::PLEN-1:0]                   lsu_paddr_o,
  output mmu_pkg::fault_e                            lsu_fault_o,
  output logic                                       wb_cyc_o,
  output logic                                       wb_stb_o,
  output logic [mmu_pkg::PLEN-1:0]                   wb_adr_o,
  input  logic [63:0]                                wb_dat_i,
  input  logic                                       wb_ack_i,
  input  logic                                       wb_err_i,
  tlb_if.ptw                                         itlb,
  tlb_if.ptw                                         dtlb
);

  // permission rules shared by hits and walked leaves
  function automatic logic perm_ok(input mmu_pkg::pte_flags_t f, input logic dside,
                                   input logic store, input logic mxr);
    logic ok;
    if (!dside) begin
      ok = f.x && f.a;
    end else if (store) begin
      ok = f.w && f.d && f.a;
    end else begin
      // mxr makes execute-only pages readable
      ok = f.a && (f.r || (f.x && mxr));
    end
    return ok;
  endfunction

  // superpages take their low ppn parts from the vaddr
  function automatic logic [mmu_pkg::PLEN-1:0] make_paddr(input logic [mmu_pkg::PPNW-1:0] ppn,
                                                          input mmu_pkg::level_e lvl,
                                                          input logic [mmu_pkg::VLEN-1:0] va);
    logic [mmu_pkg::PPNW-1:0] p;
    p = ppn;
    if (lvl == mmu_pkg::LVL1) begin
      p[17:0] = va[29:12];
    end
    if (lvl == mmu_pkg::LVL2) begin
      p[8:0] = va[20:12];
    end
    return {p, va[11:0]};
  endfunction

  mmu_pkg::ptw_state_e       state_q, state_d;
  logic                      dside_q, dside_d;
  logic                      store_q, store_d;
  logic [mmu_pkg::VLEN-1:0]  vaddr_q, vaddr_d;
  mmu_pkg::level_e           level_q, level_d;
  logic [mmu_pkg::PLEN-1:0]  pptr_q, pptr_d;
  mmu_pkg::pte_t             pte_q, pte_d;
  logic [mmu_pkg::PLEN-1:0]  paddr_q, paddr_d;
  mmu_pkg::fault_e           fault_q, fault_d;
  logic [mmu_pkg::PLEN-1:0]  walk_pptr;
  logic                      pmp_allow;
  logic                      refill;
  logic                      sel_hit;
  mmu_pkg::tlb_entry_t       sel_entry;
  logic                      pte_invalid;
  logic                      pte_leaf;
  logic                      misaligned;

  // both TLBs look up the latched vaddr
  assign itlb.lookup_vaddr = vaddr_q;
  assign dtlb.lookup_vaddr = vaddr_q;
  assign sel_hit           = dside_q ? dtlb.hit : itlb.hit;
  assign sel_entry         = dside_q ? dtlb.hit_entry : itlb.hit_entry;

  // ------------------------------
  // next pte pointer and PMP check
  // ------------------------------
  always_comb begin
    if (state_q == mmu_pkg::LOOKUP) begin
      walk_pptr = {satp_ppn_i, vaddr_q[38:30], 3'b000};
    end else if (level_q == mmu_pkg::LVL1) begin
      walk_pptr = {pte_q.ppn, vaddr_q[29:21], 3'b000};
    end else begin
      walk_pptr = {pte_q.ppn, vaddr_q[20:12], 3'b000};
    end
  end

  pmp_check #(
    .PMP_ENTRIES (PMP_ENTRIES)
  ) i_pmp_check (
    .addr_i    (walk_pptr),
    .cfg_i     (pmp_cfg_i),
    .pmpaddr_i (pmp_addr_i),
    .allow_o   (pmp_allow)
  );

  // pte decode
  assign pte_invalid = !pte_q.flags.v || (!pte_q.flags.r && pte_q.flags.w);
  assign pte_leaf    = pte_q.flags.r || pte_q.flags.x;
  assign misaligned  = ((level_q == mmu_pkg::LVL1) && (pte_q.ppn[17:0] != '0)) ||
                       ((level_q == mmu_pkg::LVL2) && (pte_q.ppn[8:0] != '0));

  // ------------------------------
  // walker FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    dside_d = dside_q;
    store_d = store_q;
    vaddr_d = vaddr_q;
    level_d = level_q;
    pptr_d  = pptr_q;
    pte_d   = pte_q;
    paddr_d = paddr_q;
    fault_d = fault_q;
    refill  = 1'b0;
    case (state_q)
      mmu_pkg::IDLE: begin
        // data side first
        if (lsu_req_i) begin
          dside_d = 1'b1;
          store_d = lsu_is_store_i;
          vaddr_d = lsu_vaddr_i;
          state_d = mmu_pkg::LOOKUP;
        end else if (ifetch_req_i) begin
          dside_d = 1'b0;
          store_d = 1'b0;
          vaddr_d = ifetch_vaddr_i;
          state_d = mmu_pkg::LOOKUP;
        end
      end
      mmu_pkg::LOOKUP: begin
        state_d = mmu_pkg::RESPOND;
        fault_d = mmu_pkg::FAULT_NONE;
        paddr_d = '0;
        if (!enable_translation_i) begin
          // bare mode, zero-extended vaddr
          paddr_d = {{(mmu_pkg::PLEN - mmu_pkg::VLEN){1'b0}}, vaddr_q};
        end else if (sel_hit) begin
          if (perm_ok(sel_entry.flags, dside_q, store_q, mxr_i)) begin
            paddr_d = make_paddr(sel_entry.ppn, sel_entry.level, vaddr_q);
          end else begin
            fault_d = mmu_pkg::FAULT_PAGE;
          end
        end else if (!pmp_allow) begin
          fault_d = mmu_pkg::FAULT_ACCESS;
        end else begin
          // miss, start at the root table
          pptr_d  = walk_pptr;
          level_d = mmu_pkg::LVL1;
          state_d = mmu_pkg::WB_READ;
        end
      end
      mmu_pkg::WB_READ: begin
        if (wb_err_i) begin
          paddr_d = '0;
          fault_d = mmu_pkg::FAULT_ACCESS;
          state_d = mmu_pkg::RESPOND;
        end else if (wb_ack_i) begin
          pte_d   = mmu_pkg::pte_t'(wb_dat_i);
          state_d = mmu_pkg::PTE_CHECK;
        end
      end
      mmu_pkg::PTE_CHECK: begin
        // page fault unless a rule below clears it
        state_d = mmu_pkg::RESPOND;
        fault_d = mmu_pkg::FAULT_PAGE;
        paddr_d = '0;
        if (!pte_invalid && pte_leaf) begin
          if (!misaligned && perm_ok(pte_q.flags, dside_q, store_q, mxr_i)) begin
            refill  = 1'b1;
            fault_d = mmu_pkg::FAULT_NONE;
            paddr_d = make_paddr(pte_q.ppn, level_q, vaddr_q);
          end
        end else if (!pte_invalid && (level_q != mmu_pkg::LVL3)) begin
          // pointer to the next table
          if (!pmp_allow) begin
            fault_d = mmu_pkg::FAULT_ACCESS;
          end else begin
            pptr_d  = walk_pptr;
            level_d = (level_q == mmu_pkg::LVL1) ? mmu_pkg::LVL2 : mmu_pkg::LVL3;
            state_d = mmu_pkg::WB_READ;
          end
        end
      end
      mmu_pkg::RESPOND: state_d = mmu_pkg::IDLE;
      mmu_pkg::DRAIN: begin
        // close the abandoned bus cycle
        if (wb_ack_i || wb_err_i) begin
          state_d = mmu_pkg::IDLE;
        end
      end
      default: state_d = mmu_pkg::IDLE;
    endcase

    // flush drops the request without a response
    if (flush_i) begin
      if ((state_q == mmu_pkg::LOOKUP) || (state_q == mmu_pkg::PTE_CHECK)) begin
        state_d = mmu_pkg::IDLE;
        refill  = 1'b0;
      end else if (state_q == mmu_pkg::WB_READ) begin
        state_d = (wb_ack_i || wb_err_i) ? mmu_pkg::IDLE : mmu_pkg::DRAIN;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mmu_pkg::IDLE;
      dside_q <= 1'b0;
    end else begin
      state_q <= state_d;
      dside_q <= dside_d;
    end
  end

  // request and walk payload
  always_ff @(posedge clk_i) begin
    store_q <= store_d;
    vaddr_q <= vaddr_d;
    level_q <= level_d;
    pptr_q  <= pptr_d;
    pte_q   <= pte_d;
    paddr_q <= paddr_d;
    fault_q <= fault_d;
  end

  // ------------------------------
  // TLB refill and outputs
  // ------------------------------
  assign itlb.refill_valid = refill && !dside_q;
  assign dtlb.refill_valid = refill && dside_q;
  assign itlb.refill_entry = {vaddr_q[38:12], pte_q.ppn, level_q, pte_q.flags};
  assign dtlb.refill_entry = {vaddr_q[38:12], pte_q.ppn, level_q, pte_q.flags};

  // bus cycle stays open through DRAIN
  assign wb_cyc_o = (state_q == mmu_pkg::WB_READ) || (state_q == mmu_pkg::DRAIN);
  assign wb_stb_o = wb_cyc_o;
  assign wb_adr_o = pptr_q;

  assign ifetch_valid_o = (state_q == mmu_pkg::RESPOND) && !dside_q;
  assign lsu_valid_o    = (state_q == mmu_pkg::RESPOND) && dside_q;
  assign ifetch_paddr_o = ifetch_valid_o ? paddr_q : '0;
  assign lsu_paddr_o    = lsu_valid_o ? paddr_q : '0;
  assign ifetch_fault_o = ifetch_valid_o ? fault_q : mmu_pkg::FAULT_NONE;
  assign lsu_fault_o    = lsu_valid_o ? fault_q : mmu_pkg::FAULT_NONE;

endmodule

// ==== source/tlb.sv ====
/*
 * fully associative TLB: combinational lookup with superpage masking,
 * round-robin refill and flush
 */
`timescale 1ns/100ps

module tlb #(
  parameter int TLB_ENTRIES = 4
) (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  tlb_if.tlb  bus
);

  localparam int IDXW = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  mmu_pkg::tlb_entry_t              entries_q [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]           valid_q;
  logic [IDXW-1:0]                  rr_ptr_q;
  logic [mmu_pkg::VPNW-1:0]         lookup_vpn;
  logic [TLB_ENTRIES-1:0]           match;

  assign lookup_vpn = bus.lookup_vaddr[mmu_pkg::VLEN-1:12];

  // ------------------------------
  // lookup
  // ------------------------------
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // vpn[2] always compared
      match[i] = valid_q[i] && (entries_q[i].vpn[26:18] == lookup_vpn[26:18]);
      // vpn[1] ignored for 1G pages
      if (entries_q[i].level != mmu_pkg::LVL1) begin
        match[i] = match[i] && (entries_q[i].vpn[17:9] == lookup_vpn[17:9]);
      end
      // vpn[0] only compared for 4K pages
      if (entries_q[i].level == mmu_pkg::LVL3) begin
        match[i] = match[i] && (entries_q[i].vpn[8:0] == lookup_vpn[8:0]);
      end
    end
  end

  // walk downward so the lowest matching slot wins
  always_comb begin
    bus.hit       = 1'b0;
    bus.hit_entry = entries_q[0];
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        bus.hit       = 1'b1;
        bus.hit_entry = entries_q[i];
      end
    end
  end

  // ------------------------------
  // refill and flush
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rr_ptr_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (bus.refill_valid) begin
      valid_q[rr_ptr_q] <= 1'b1;
      // round-robin victim pointer, wraps at the last slot
      if (rr_ptr_q == IDXW'(TLB_ENTRIES - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (bus.refill_valid && !flush_i) begin
      entries_q[rr_ptr_q] <= bus.refill_entry;
    end
  end

endmodule

// ==== source/tlb_if.sv ====
/*
 * lookup and refill interface between one TLB and the walker
 */
`timescale 1ns/100ps

interface tlb_if;
  // lookup, answered in the same cycle
  logic [mmu_pkg::VLEN-1:0] lookup_vaddr;
  logic                     hit;
  mmu_pkg::tlb_entry_t      hit_entry;
  // one-cycle refill pulse
  logic                     refill_valid;
  mmu_pkg::tlb_entry_t      refill_entry;

  modport tlb (
    input  lookup_vaddr, refill_valid, refill_entry,
    output hit, hit_entry
  );

  modport ptw (
    output lookup_vaddr, refill_valid, refill_entry,
    input  hit, hit_entry
  );

endinterface

// ==== src.f ====
source/mmu_pkg.sv
source/tlb_if.sv
source/tlb.sv
source/pmp_check.sv
source/ptw.sv
source/mmu_top.sv
tests/tb_mmu.sv

// ==== tests/mmu_tests.txt ====
# M addr data | C satp mxr en {mode r pmpaddr}x4 err_en err_addr (mode 0 off 1 tor 2 napot)
# R side(0 fetch 1 lsu) vaddr store flush bus_reads paddr fault(0 none 1 page 2 access)
M 1000 801
M 1008 100000cf
M 1010 100004cf
M 1018 1001
M 1020 8001
M 1028 c001
M 2000 c01
M 3000 200cf
M 3008 2044b
M 3010 208c7
M 3018 20c47
M 3020 21049
M 3028 1001
M 3030 0
M 3038 214cf
M 4000 800cf
M 4008 804cf
M 30000 1000cf
C 1 0 1 1 1 4000 2 1 c1ff 0 0 0 0 0 0 0 0
R 1 123 0 0 3 80123 0
R 0 1456 0 0 3 81456 0
R 1 123 0 0 0 80123 0
R 1 7ff 0 0 0 807ff 0
R 0 1abc 0 0 0 81abc 0
R 1 123 0 1 3 80123 0
R 1 8 1 0 0 80008 0
R 0 2000 0 0 3 0 1
R 1 3000 1 0 3 0 1
R 1 4010 0 0 3 0 1
C 1 1 1 1 1 4000 2 1 c1ff 0 0 0 0 0 0 0 0
R 1 4010 0 0 3 84010 0
C 1 0 1 1 1 4000 2 1 c1ff 0 0 0 0 0 0 0 0
R 1 4010 0 0 0 0 1
R 1 43456789 0 0 1 43456789 0
R 1 80000010 0 0 1 0 1
R 1 c01abcde 0 0 2 3abcde 0
R 1 c0200123 0 0 2 0 1
R 1 6000 0 0 3 0 1
R 1 5000 0 0 3 0 1
R 1 140000055 0 0 2 400055 0
R 1 100000000 0 0 1 0 2
C 1 0 1 1 1 4000 2 1 c1ff 0 0 0 0 0 0 1 3038
R 1 7000 0 0 3 0 2
C 1 0 0 1 1 4000 2 1 c1ff 0 0 0 0 0 0 0 0
R 1 7f12345678 0 0 0 7f12345678 0
R 0 1456 0 0 0 1456 0
C 20 0 1 1 1 4000 2 1 c1ff 0 0 0 0 0 0 0 0
R 0 0 0 0 0 0 2

// ==== tests/tb_mmu.sv ====
/*
 * MMU testbench: clock, reset, Wishbone memory model,
 * file-driven requests with checks and a cycle timeout
 */
`timescale 1ns/100ps

module tb_mmu;

  localparam int PMP_N = 4;
  localparam int TLB_N = 4;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               enable_translation_i;
  logic                               mxr_i;
  logic [mmu_pkg::PPNW-1:0]           satp_ppn_i;
  mmu_pkg::pmp_cfg_t [PMP_N-1:0]      pmp_cfg_i;
  logic [PMP_N-1:0][mmu_pkg::PLEN-3:0] pmp_addr_i;
  logic                               ifetch_req_i;
  logic [mmu_pkg::VLEN-1:0]           ifetch_vaddr_i;
  logic                               ifetch_valid_o;
  logic [mmu_pkg::PLEN-1:0]           ifetch_paddr_o;
  mmu_pkg::fault_e                    ifetch_fault_o;
  logic                               lsu_req_i;
  logic [mmu_pkg::VLEN-1:0]           lsu_vaddr_i;
  logic                               lsu_is_store_i;
  logic                               lsu_valid_o;
  logic [mmu_pkg::PLEN-1:0]           lsu_paddr_o;
  mmu_pkg::fault_e                    lsu_fault_o;
  logic                               wb_cyc_o;
  logic                               wb_stb_o;
  logic [mmu_pkg::PLEN-1:0]           wb_adr_o;
  logic [63:0]                        wb_dat_i;
  logic                               wb_ack_i;
  logic                               wb_err_i;

  // memory image, words not listed read as zero
  logic [63:0]              mem [logic [mmu_pkg::PLEN-1:0]];
  logic                     err_en;
  logic [mmu_pkg::PLEN-1:0] err_addr;
  // parsed C and R lines, in file order
  logic [7:0]               kinds [$];
  logic [63:0]              fields [$];
  int                       num_requests;
  int                       errors;
  int                       checks;
  int                       cycles;
  int                       limit;
  int                       bus_reads;
  int                       wait_left;
  logic                     bus_busy;
  int                       seed = 32'h5cc8_352a;

  mmu_top #(
    .TLB_ENTRIES (TLB_N),
    .PMP_ENTRIES (PMP_N)
  ) dut_i (.*);

  // 20 ns clock
  always #10 clk_i = ~clk_i;

  // ------------------------------
  // timeout and memory model
  // ------------------------------
  always @(posedge clk_i) begin
    cycles++;
    if ((limit > 0) && (cycles > limit)) begin
      $display("timeout after %0d cycles, a request never completed", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] read_word(input logic [mmu_pkg::PLEN-1:0] addr);
    logic [63:0] word;
    word = '0;
    if (mem.exists(addr)) begin
      word = mem[addr];
    end
    return word;
  endfunction

  // wishbone slave, 0 to 3 wait cycles per read
  always @(posedge clk_i) begin
    #2;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    if (wb_cyc_o && wb_stb_o) begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        bus_reads = bus_reads + 1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0) begin
        bus_busy = 1'b0;
        if (err_en && (wb_adr_o == err_addr)) begin
          wb_err_i = 1'b1;
        end else begin
          wb_dat_i = read_word(wb_adr_o);
          wb_ack_i = 1'b1;
        end
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // ------------------------------
  // checks and file parsing
  // ------------------------------
  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [63:0] next_field();
    return fields.pop_front();
  endfunction

  task automatic load_tests(input int fd);
    int          rc;
    logic [7:0]  tag;
    logic [63:0] v;
    logic [63:0] data;
    logic [8*160-1:0] rest;
    while (!$feof(fd)) begin
      rc = $fscanf(fd, " %c", tag);
      if (rc == 1) begin
        case (tag)
          "#": rc = $fgets(rest, fd);
          "M": begin
            rc = $fscanf(fd, "%h %h", v, data);
            mem[v[mmu_pkg::PLEN-1:0]] = data;
          end
          "C", "R": begin
            kinds.push_back(tag);
            // C lines have 17 fields, R lines 7
            for (int i = 0; i < ((tag == "C") ? 17 : 7); i++) begin
              rc = $fscanf(fd, "%h", v);
              fields.push_back(v);
            end
            if (tag == "R") begin
              num_requests++;
            end
          end
          default: begin
            errors++;
            $display("test file has a line with unknown type '%c'", tag);
            rc = $fgets(rest, fd);
          end
        endcase
      end
    end
  endtask

  task automatic apply_config();
    logic [63:0] v;
    v = next_field();
    satp_ppn_i = v[mmu_pkg::PPNW-1:0];
    v = next_field();
    mxr_i = v[0];
    v = next_field();
    enable_translation_i = v[0];
    for (int i = 0; i < PMP_N; i++) begin
      v = next_field();
      pmp_cfg_i[i].mode = mmu_pkg::pmp_mode_e'(v[1:0]);
      v = next_field();
      pmp_cfg_i[i].r = v[0];
      v = next_field();
      pmp_addr_i[i] = v[mmu_pkg::PLEN-3:0];
    end
    v = next_field();
    err_en = v[0];
    v = next_field();
    err_addr = v[mmu_pkg::PLEN-1:0];
  endtask

  // ------------------------------
  // one translation request
  // ------------------------------
  task automatic run_request();
    logic [63:0]              f [7];
    logic                     side;
    logic                     done;
    logic [mmu_pkg::PLEN-1:0] paddr;
    logic [1:0]               fault;
    for (int i = 0; i < 7; i++) begin
      f[i] = next_field();
    end
    side = f[0][0];
    // at least one idle cycle between requests
    @(posedge clk_i);
    #2;
    if (f[3][0]) begin
      flush_i = 1'b1;
      @(posedge clk_i);
      #2;
      flush_i = 1'b0;
    end
    bus_reads = 0;
    if (side) begin
      lsu_req_i      = 1'b1;
      lsu_vaddr_i    = f[1][mmu_pkg::VLEN-1:0];
      lsu_is_store_i = f[2][0];
    end else begin
      ifetch_req_i   = 1'b1;
      ifetch_vaddr_i = f[1][mmu_pkg::VLEN-1:0];
    end
    // outputs sampled mid cycle
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      assert (!(side ? ifetch_valid_o : lsu_valid_o)) else begin
        errors++;
        $display("valid pulsed on the wrong requester side at %0t", $time);
      end
      if (side ? lsu_valid_o : ifetch_valid_o) begin
        paddr = side ? lsu_paddr_o : ifetch_paddr_o;
        fault = side ? lsu_fault_o : ifetch_fault_o;
        done  = 1'b1;
      end
    end
    @(posedge clk_i);
    #2;
    lsu_req_i    = 1'b0;
    ifetch_req_i = 1'b0;
    check_value(side ? "lsu_paddr_o" : "ifetch_paddr_o", f[5], 64'(paddr));
    check_value(side ? "lsu_fault_o" : "ifetch_fault_o", f[6], 64'(fault));
    check_value("wishbone read count", f[4], 64'(bus_reads));
  endtask

  initial begin
    int fd;
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    flush_i              = 1'b0;
    enable_translation_i = 1'b0;
    mxr_i                = 1'b0;
    satp_ppn_i           = '0;
    pmp_cfg_i            = '0;
    pmp_addr_i           = '0;
    ifetch_req_i         = 1'b0;
    ifetch_vaddr_i       = '0;
    lsu_req_i            = 1'b0;
    lsu_vaddr_i          = '0;
    lsu_is_store_i       = 1'b0;
    wb_dat_i             = '0;
    wb_ack_i             = 1'b0;
    wb_err_i             = 1'b0;
    err_en               = 1'b0;
    err_addr             = '0;
    bus_busy             = 1'b0;
    fd = $fopen("tests/mmu_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/mmu_tests.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      load_tests(fd);
      $fclose(fd);
      limit = num_requests * 200;
      // reset for 4 cycles
      repeat (4) @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      check_value("wb_cyc_o", 64'd0, 64'(wb_cyc_o));
      check_value("wb_stb_o", 64'd0, 64'(wb_stb_o));
      check_value("ifetch_valid_o", 64'd0, 64'(ifetch_valid_o));
      check_value("lsu_valid_o", 64'd0, 64'(lsu_valid_o));
      check_value("itlb refill_valid", 64'd0, 64'(dut_i.itlb_bus.refill_valid));
      check_value("dtlb refill_valid", 64'd0, 64'(dut_i.dtlb_bus.refill_valid));
      while (kinds.size() > 0) begin
        if (kinds.pop_front() == "C") begin
          apply_config();
        end else begin
          run_request();
        end
      end
      @(posedge clk_i);
      $display("requests %0d, checks %0d, errors %0d", num_requests, checks, errors);
      if (errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule
